//--- source/rv32_isa_pkg.sv
package rv32_isa_pkg;

  // major opcodes of the supported subset
  typedef logic [6:0] opcode_t;

  localparam opcode_t op_lui   = 7'b01_101_11;
  localparam opcode_t op_auipc = 7'b00_101_11;
  localparam opcode_t op_imm   = 7'b00_100_11;
  localparam opcode_t op_reg   = 7'b01_100_11;

  // funct3 field values, shared by OP and OP-IMM
  typedef logic [2:0] funct3_t;

  localparam funct3_t f3_add_sub = 3'b000;
  localparam funct3_t f3_sll     = 3'b001;
  localparam funct3_t f3_slt     = 3'b010;
  localparam funct3_t f3_sltu    = 3'b011;
  localparam funct3_t f3_xor     = 3'b100;
  localparam funct3_t f3_srl_sra = 3'b101;
  localparam funct3_t f3_or      = 3'b110;
  localparam funct3_t f3_and     = 3'b111;

  // funct7 field values
  typedef logic [6:0] funct7_t;

  localparam funct7_t f7_base = 7'b00000_00;
  // selects sub and the arithmetic right shift
  localparam funct7_t f7_alt  = 7'b01000_00;

  // operations of the integer ALU
  typedef enum logic [3:0] {
    add,
    sub,
    sll,
    slt,
    sltu,
    xor_op,
    srl,
    sra,
    or_op,
    and_op
  } alu_op_t;

endpackage

//--- source/pipe_pkg.sv
package pipe_pkg;

  // one data word of the integer datapath
  typedef logic [31:0] word_t;

  // architectural register index
  typedef logic [4:0] reg_idx_t;

  // where an operand is taken from in the decode cycle
  typedef enum logic [1:0] {
    from_regfile,
    // result of the instruction now in execute
    from_execute,
    // result register of the instruction now retiring
    from_writeback
  } fwd_sel_t;

endpackage

//--- source/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  accept,
  input  pipe_pkg::word_t       inst,
  input  pipe_pkg::word_t       pc,
  output pipe_pkg::reg_idx_t    rs1,
  output pipe_pkg::reg_idx_t    rs2,
  output pipe_pkg::reg_idx_t    rd,
  output logic                  rd_wen,
  output pipe_pkg::word_t       imm,
  output logic                  use_imm,
  output logic                  use_pc,
  output logic                  zero_a,
  output rv32_isa_pkg::alu_op_t alu_op,
  output logic                  illegal,
  output pipe_pkg::word_t       d_pc
);

  pipe_pkg::word_t       inst_q;
  rv32_isa_pkg::opcode_t opcode;
  rv32_isa_pkg::funct3_t funct3;
  rv32_isa_pkg::funct7_t funct7;
  logic                  is_lui;
  logic                  is_auipc;
  logic                  is_op_imm;
  logic                  is_op_reg;
  logic                  f7_is_base;
  logic                  f7_is_alt;
  pipe_pkg::word_t       i_imm;
  pipe_pkg::word_t       u_imm;
  rv32_isa_pkg::alu_op_t base_op;

  // held word starts as zero, which decodes as illegal
  always_ff @(posedge clock) begin
    if (reset) begin
      inst_q <= '0;
    end else if (accept) begin
      inst_q <= inst;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      d_pc <= pc;
    end
  end

  assign opcode = inst_q[6:0];
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];

  assign is_lui    = opcode == rv32_isa_pkg::op_lui;
  assign is_auipc  = opcode == rv32_isa_pkg::op_auipc;
  assign is_op_imm = opcode == rv32_isa_pkg::op_imm;
  assign is_op_reg = opcode == rv32_isa_pkg::op_reg;

  assign f7_is_base = funct7 == rv32_isa_pkg::f7_base;
  assign f7_is_alt  = funct7 == rv32_isa_pkg::f7_alt;

  assign rs1 = inst_q[19:15];
  assign rs2 = inst_q[24:20];
  assign rd  = inst_q[11:7];

  // I-type for OP-IMM, U-type for LUI and AUIPC
  assign i_imm = {{20{inst_q[31]}}, inst_q[31:20]};
  assign u_imm = {inst_q[31:12], 12'b0};
  assign imm   = (is_lui || is_auipc) ? u_imm : i_imm;

  assign use_imm = is_op_imm || is_lui || is_auipc;
  // auipc adds the pc, lui adds zero
  assign use_pc  = is_auipc;
  assign zero_a  = is_lui;
  assign rd_wen  = is_op_imm || is_op_reg || is_lui || is_auipc;

  // funct3 picks the operation in both OP and OP-IMM
  always_comb begin
    case (funct3)
      rv32_isa_pkg::f3_add_sub: base_op = rv32_isa_pkg::add;
      rv32_isa_pkg::f3_sll:     base_op = rv32_isa_pkg::sll;
      rv32_isa_pkg::f3_slt:     base_op = rv32_isa_pkg::slt;
      rv32_isa_pkg::f3_sltu:    base_op = rv32_isa_pkg::sltu;
      rv32_isa_pkg::f3_xor:     base_op = rv32_isa_pkg::xor_op;
      rv32_isa_pkg::f3_srl_sra: base_op = f7_is_alt ? rv32_isa_pkg::sra : rv32_isa_pkg::srl;
      rv32_isa_pkg::f3_or:      base_op = rv32_isa_pkg::or_op;
      default:                  base_op = rv32_isa_pkg::and_op;
    endcase
  end

  always_comb begin
    alu_op  = rv32_isa_pkg::add;
    illegal = 1'b0;
    if (is_lui || is_auipc) begin
      alu_op = rv32_isa_pkg::add;
    end else if (is_op_imm) begin
      // addi stays add whatever bit 30 of its immediate holds
      alu_op = base_op;
      if (funct3 == rv32_isa_pkg::f3_sll) begin
        illegal = !f7_is_base;
      end else if (funct3 == rv32_isa_pkg::f3_srl_sra) begin
        illegal = !(f7_is_base || f7_is_alt);
      end
    end else if (is_op_reg) begin
      if (funct3 == rv32_isa_pkg::f3_add_sub && f7_is_alt) begin
        alu_op = rv32_isa_pkg::sub;
      end else begin
        alu_op = base_op;
      end
      // the alternate funct7 only exists for sub and sra
      illegal = !(f7_is_base || (f7_is_alt && (funct3 == rv32_isa_pkg::f3_add_sub ||
                                               funct3 == rv32_isa_pkg::f3_srl_sra)));
    end else begin
      illegal = 1'b1;
    end
  end

endmodule

//--- source/register_file.sv
`timescale 1ns/1ns

module register_file #(
  parameter int register_count = 32
) (
  input  logic               clock,
  input  logic               reset,
  input  pipe_pkg::reg_idx_t rs1,
  input  pipe_pkg::reg_idx_t rs2,
  output pipe_pkg::word_t    rdata1,
  output pipe_pkg::word_t    rdata2,
  input  logic               wen,
  input  pipe_pkg::reg_idx_t waddr,
  input  pipe_pkg::word_t    wdata
);

  pipe_pkg::word_t regs [register_count];

  // x0 and indices past the end are never stored
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < register_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0 && waddr < register_count) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational reads, x0 reads as zero
  assign rdata1 = (rs1 == '0 || rs1 >= register_count) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0 || rs2 >= register_count) ? '0 : regs[rs2];

endmodule

//--- source/int_alu.sv
`timescale 1ns/1ns

module int_alu (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  e_valid,
  input  logic                  e_wen,
  input  pipe_pkg::reg_idx_t    e_rd,
  input  logic                  illegal,
  input  pipe_pkg::word_t       rdata1,
  input  pipe_pkg::word_t       rdata2,
  input  pipe_pkg::fwd_sel_t    fwd_sel_a,
  input  pipe_pkg::fwd_sel_t    fwd_sel_b,
  input  pipe_pkg::word_t       imm,
  input  logic                  use_imm,
  input  logic                  use_pc,
  input  logic                  zero_a,
  input  pipe_pkg::word_t       d_pc,
  input  rv32_isa_pkg::alu_op_t alu_op,
  output logic                  wb_valid,
  output pipe_pkg::reg_idx_t    wb_rd,
  output pipe_pkg::word_t       wb_data,
  output logic                  wb_wen,
  output logic                  wb_illegal
);

  pipe_pkg::word_t       fwd_a;
  pipe_pkg::word_t       fwd_b;
  pipe_pkg::word_t       src_a;
  pipe_pkg::word_t       src_b;
  pipe_pkg::word_t       op_a;
  pipe_pkg::word_t       op_b;
  rv32_isa_pkg::alu_op_t e_op;
  logic                  e_illegal;
  logic [4:0]            shamt;
  pipe_pkg::word_t       ex_result;

  // decode cycle: pick the freshest copy of each source register
  always_comb begin
    case (fwd_sel_a)
      pipe_pkg::from_execute:   fwd_a = ex_result;
      pipe_pkg::from_writeback: fwd_a = wb_data;
      default:                  fwd_a = rdata1;
    endcase
    case (fwd_sel_b)
      pipe_pkg::from_execute:   fwd_b = ex_result;
      pipe_pkg::from_writeback: fwd_b = wb_data;
      default:                  fwd_b = rdata2;
    endcase
  end

  assign src_a = zero_a ? '0 : (use_pc ? d_pc : fwd_a);
  assign src_b = use_imm ? imm : fwd_b;

  // execute stage operand register
  always_ff @(posedge clock) begin
    op_a      <= src_a;
    op_b      <= src_b;
    e_op      <= alu_op;
    e_illegal <= illegal;
  end

  assign shamt = op_b[4:0];

  always_comb begin
    case (e_op)
      rv32_isa_pkg::add:    ex_result = op_a + op_b;
      rv32_isa_pkg::sub:    ex_result = op_a - op_b;
      rv32_isa_pkg::sll:    ex_result = op_a << shamt;
      rv32_isa_pkg::slt:    ex_result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv32_isa_pkg::sltu:   ex_result = {31'b0, op_a < op_b};
      rv32_isa_pkg::xor_op: ex_result = op_a ^ op_b;
      rv32_isa_pkg::srl:    ex_result = op_a >> shamt;
      rv32_isa_pkg::sra:    ex_result = $signed(op_a) >>> shamt;
      rv32_isa_pkg::or_op:  ex_result = op_a | op_b;
      rv32_isa_pkg::and_op: ex_result = op_a & op_b;
      default:              ex_result = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
      wb_wen   <= 1'b0;
    end else begin
      wb_valid <= e_valid;
      wb_wen   <= e_wen;
    end
  end

  // illegal instructions retire with a zero result
  always_ff @(posedge clock) begin
    wb_rd      <= e_rd;
    wb_data    <= e_illegal ? '0 : ex_result;
    wb_illegal <= e_illegal;
  end

endmodule

//--- source/pipe_control.sv
`timescale 1ns/1ns

module pipe_control (
  input  logic               clock,
  input  logic               reset,
  input  logic               inst_valid,
  output logic               inst_ready,
  output logic               accept,
  output logic               d_valid,
  input  pipe_pkg::reg_idx_t rs1,
  input  pipe_pkg::reg_idx_t rs2,
  input  pipe_pkg::reg_idx_t d_rd,
  input  logic               d_rd_wen,
  input  logic               illegal,
  output logic               e_valid,
  output pipe_pkg::reg_idx_t e_rd,
  output logic               e_wen,
  input  pipe_pkg::reg_idx_t w_rd,
  input  logic               w_wen,
  output pipe_pkg::fwd_sel_t fwd_sel_a,
  output pipe_pkg::fwd_sel_t fwd_sel_b
);

  // younger stage first, x0 never forwards
  function automatic pipe_pkg::fwd_sel_t pick_source(
    input pipe_pkg::reg_idx_t src,
    input pipe_pkg::reg_idx_t ex_rd,
    input logic               ex_wen,
    input pipe_pkg::reg_idx_t wr_rd,
    input logic               wr_wen
  );
    if (src != '0 && ex_wen && src == ex_rd) begin
      return pipe_pkg::from_execute;
    end else if (src != '0 && wr_wen && src == wr_rd) begin
      return pipe_pkg::from_writeback;
    end
    return pipe_pkg::from_regfile;
  endfunction

  // nothing ever stalls, so ready only drops during reset
  assign accept = inst_valid && inst_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      inst_ready <= 1'b0;
      d_valid    <= 1'b0;
      e_valid    <= 1'b0;
      e_wen      <= 1'b0;
    end else begin
      inst_ready <= 1'b1;
      d_valid    <= accept;
      e_valid    <= d_valid;
      e_wen      <= d_valid && d_rd_wen && !illegal;
    end
  end

  always_ff @(posedge clock) begin
    e_rd <= d_rd;
  end

  assign fwd_sel_a = pick_source(rs1, e_rd, e_wen, w_rd, w_wen);
  assign fwd_sel_b = pick_source(rs2, e_rd, e_wen, w_rd, w_wen);

endmodule

//--- source/int_core.sv
`timescale 1ns/1ns

module int_core #(
  parameter int register_count = 32
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               inst_valid,
  output logic               inst_ready,
  input  pipe_pkg::word_t    inst,
  input  pipe_pkg::word_t    pc,
  output logic               wb_valid,
  output pipe_pkg::reg_idx_t wb_rd,
  output pipe_pkg::word_t    wb_data,
  output logic               wb_illegal
);

  logic                  accept;
  logic                  d_valid;
  pipe_pkg::reg_idx_t    rs1;
  pipe_pkg::reg_idx_t    rs2;
  pipe_pkg::reg_idx_t    d_rd;
  logic                  d_rd_wen;
  pipe_pkg::word_t       imm;
  logic                  use_imm;
  logic                  use_pc;
  logic                  zero_a;
  rv32_isa_pkg::alu_op_t alu_op;
  logic                  illegal;
  pipe_pkg::word_t       d_pc;
  pipe_pkg::word_t       rdata1;
  pipe_pkg::word_t       rdata2;
  logic                  e_valid;
  pipe_pkg::reg_idx_t    e_rd;
  logic                  e_wen;
  logic                  wb_wen;
  pipe_pkg::fwd_sel_t    fwd_sel_a;
  pipe_pkg::fwd_sel_t    fwd_sel_b;

  pipe_control u_control (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .accept     (accept),
    .d_valid    (d_valid),
    .rs1        (rs1),
    .rs2        (rs2),
    .d_rd       (d_rd),
    .d_rd_wen   (d_rd_wen),
    .illegal    (illegal),
    .e_valid    (e_valid),
    .e_rd       (e_rd),
    .e_wen      (e_wen),
    .w_rd       (wb_rd),
    .w_wen      (wb_wen),
    .fwd_sel_a  (fwd_sel_a),
    .fwd_sel_b  (fwd_sel_b)
  );

  inst_decoder u_decoder (
    .clock   (clock),
    .reset   (reset),
    .accept  (accept),
    .inst    (inst),
    .pc      (pc),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (d_rd),
    .rd_wen  (d_rd_wen),
    .imm     (imm),
    .use_imm (use_imm),
    .use_pc  (use_pc),
    .zero_a  (zero_a),
    .alu_op  (alu_op),
    .illegal (illegal),
    .d_pc    (d_pc)
  );

  // written from the retiring result
  register_file #(
    .register_count (register_count)
  ) u_regfile (
    .clock  (clock),
    .reset  (reset),
    .rs1    (rs1),
    .rs2    (rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wen    (wb_wen),
    .waddr  (wb_rd),
    .wdata  (wb_data)
  );

  int_alu u_alu (
    .clock      (clock),
    .reset      (reset),
    .e_valid    (e_valid),
    .e_wen      (e_wen),
    .e_rd       (e_rd),
    .illegal    (illegal),
    .rdata1     (rdata1),
    .rdata2     (rdata2),
    .fwd_sel_a  (fwd_sel_a),
    .fwd_sel_b  (fwd_sel_b),
    .imm        (imm),
    .use_imm    (use_imm),
    .use_pc     (use_pc),
    .zero_a     (zero_a),
    .d_pc       (d_pc),
    .alu_op     (alu_op),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .wb_wen     (wb_wen),
    .wb_illegal (wb_illegal)
  );

endmodule

//--- testbench/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
  parameter int period       = 20,
  parameter int reset_cycles = 4
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  // release one step after the last reset edge, in step with the stimulus
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;
  end

endmodule

//--- testbench/core_tb.sv
`timescale 1ns/1ns

module core_tb;

  // longest random idle gap before a row, in cycles
  localparam int max_gap = 3;

  logic               clock;
  logic               reset;
  logic               inst_valid;
  logic               inst_ready;
  pipe_pkg::word_t    inst;
  pipe_pkg::word_t    pc;
  logic               wb_valid;
  pipe_pkg::reg_idx_t wb_rd;
  pipe_pkg::word_t    wb_data;
  logic               wb_illegal;

  // stimulus table, one entry per instruction, in retirement order
  string              row_name [$];
  pipe_pkg::word_t    row_inst [$];
  pipe_pkg::word_t    row_pc [$];
  pipe_pkg::reg_idx_t row_rd [$];
  pipe_pkg::word_t    row_data [$];
  logic               row_illegal [$];
  bit                 row_gap [$];
  bit                 allow_gaps;

  int unsigned        accept_cycle [$];
  int unsigned        cycle_count = 0;
  int unsigned        cycle_limit = 0;
  int                 next_check = 0;
  int                 value_errors = 0;
  int                 protocol_errors = 0;

  clock_gen #(
    .period       (20),
    .reset_cycles (4)
  ) u_clock (
    .clock (clock),
    .reset (reset)
  );

  int_core #(
    .register_count (32)
  ) u_dut (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .inst       (inst),
    .pc         (pc),
    .wb_valid   (wb_valid),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .wb_illegal (wb_illegal)
  );

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
  end

  // instruction assembly from the RV32I field layout
  function automatic pipe_pkg::word_t r_type_word(
    input rv32_isa_pkg::funct3_t funct3,
    input logic                  alt,
    input pipe_pkg::reg_idx_t    rd,
    input pipe_pkg::reg_idx_t    rs1,
    input pipe_pkg::reg_idx_t    rs2
  );
    rv32_isa_pkg::funct7_t funct7;
    funct7 = alt ? rv32_isa_pkg::f7_alt : rv32_isa_pkg::f7_base;
    return {funct7, rs2, rs1, funct3, rd, rv32_isa_pkg::op_reg};
  endfunction

  function automatic pipe_pkg::word_t i_type_word(
    input rv32_isa_pkg::funct3_t funct3,
    input pipe_pkg::reg_idx_t    rd,
    input pipe_pkg::reg_idx_t    rs1,
    input logic [11:0]           imm
  );
    return {imm, rs1, funct3, rd, rv32_isa_pkg::op_imm};
  endfunction

  function automatic pipe_pkg::word_t u_type_word(
    input rv32_isa_pkg::opcode_t opcode,
    input pipe_pkg::reg_idx_t    rd,
    input logic [19:0]           imm
  );
    return {imm, rd, opcode};
  endfunction

  function automatic void add_row(
    input string              name,
    input pipe_pkg::word_t    word,
    input pipe_pkg::word_t    addr,
    input pipe_pkg::reg_idx_t rd,
    input pipe_pkg::word_t    data,
    input logic               ill
  );
    row_name.push_back(name);
    row_inst.push_back(word);
    row_pc.push_back(addr);
    row_rd.push_back(rd);
    row_data.push_back(data);
    row_illegal.push_back(ill);
    row_gap.push_back(allow_gaps);
  endfunction

  task automatic build_table();
    // x1 = 0x123 and x2 = -5 feed the immediate ops
    add_row("addi", i_type_word(rv32_isa_pkg::f3_add_sub, 5'd1, 5'd0, 12'h123),
            32'h0000_0100, 5'd1, 32'h0000_0123, 1'b0);
    add_row("addi_neg", i_type_word(rv32_isa_pkg::f3_add_sub, 5'd2, 5'd0, 12'hffb),
            32'h0000_0104, 5'd2, 32'hffff_fffb, 1'b0);
    add_row("slti", i_type_word(rv32_isa_pkg::f3_slt, 5'd3, 5'd2, 12'hffc),
            32'h0000_0108, 5'd3, 32'h0000_0001, 1'b0);
    add_row("sltiu", i_type_word(rv32_isa_pkg::f3_sltu, 5'd4, 5'd2, 12'h005),
            32'h0000_010c, 5'd4, 32'h0000_0000, 1'b0);
    add_row("sltiu_neg_imm", i_type_word(rv32_isa_pkg::f3_sltu, 5'd5, 5'd1, 12'hfff),
            32'h0000_0110, 5'd5, 32'h0000_0001, 1'b0);
    add_row("xori", i_type_word(rv32_isa_pkg::f3_xor, 5'd6, 5'd1, 12'hff0),
            32'h0000_0114, 5'd6, 32'hffff_fed3, 1'b0);
    add_row("ori", i_type_word(rv32_isa_pkg::f3_or, 5'd7, 5'd1, 12'h0f0),
            32'h0000_0118, 5'd7, 32'h0000_01f3, 1'b0);
    add_row("andi", i_type_word(rv32_isa_pkg::f3_and, 5'd8, 5'd2, 12'h07f),
            32'h0000_011c, 5'd8, 32'h0000_007b, 1'b0);
    add_row("slli", i_type_word(rv32_isa_pkg::f3_sll, 5'd9, 5'd1, 12'h004),
            32'h0000_0120, 5'd9, 32'h0000_1230, 1'b0);
    add_row("srli", i_type_word(rv32_isa_pkg::f3_srl_sra, 5'd10, 5'd2, 12'h004),
            32'h0000_0124, 5'd10, 32'h0fff_ffff, 1'b0);
    // bit 10 of the immediate selects the arithmetic shift
    add_row("srai", i_type_word(rv32_isa_pkg::f3_srl_sra, 5'd11, 5'd2, 12'h401),
            32'h0000_0128, 5'd11, 32'hffff_fffd, 1'b0);

    // dependent chain with no gaps, operands come from E, W or the register file
    add_row("add", r_type_word(rv32_isa_pkg::f3_add_sub, 1'b0, 5'd12, 5'd1, 5'd2),
            32'h0000_012c, 5'd12, 32'h0000_011e, 1'b0);
    add_row("sub_fwd_e", r_type_word(rv32_isa_pkg::f3_add_sub, 1'b1, 5'd13, 5'd12, 5'd1),
            32'h0000_0130, 5'd13, 32'hffff_fffb, 1'b0);
    add_row("sll_fwd_w", r_type_word(rv32_isa_pkg::f3_sll, 1'b0, 5'd14, 5'd12, 5'd3),
            32'h0000_0134, 5'd14, 32'h0000_023c, 1'b0);
    add_row("slt", r_type_word(rv32_isa_pkg::f3_slt, 1'b0, 5'd15, 5'd13, 5'd14),
            32'h0000_0138, 5'd15, 32'h0000_0001, 1'b0);
    add_row("sltu", r_type_word(rv32_isa_pkg::f3_sltu, 1'b0, 5'd16, 5'd13, 5'd14),
            32'h0000_013c, 5'd16, 32'h0000_0000, 1'b0);
    add_row("xor", r_type_word(rv32_isa_pkg::f3_xor, 1'b0, 5'd17, 5'd14, 5'd13),
            32'h0000_0140, 5'd17, 32'hffff_fdc7, 1'b0);
    add_row("srl", r_type_word(rv32_isa_pkg::f3_srl_sra, 1'b0, 5'd18, 5'd17, 5'd3),
            32'h0000_0144, 5'd18, 32'h7fff_fee3, 1'b0);
    add_row("sra", r_type_word(rv32_isa_pkg::f3_srl_sra, 1'b1, 5'd19, 5'd17, 5'd3),
            32'h0000_0148, 5'd19, 32'hffff_fee3, 1'b0);
    add_row("or", r_type_word(rv32_isa_pkg::f3_or, 1'b0, 5'd20, 5'd18, 5'd19),
            32'h0000_014c, 5'd20, 32'hffff_fee3, 1'b0);
    add_row("and", r_type_word(rv32_isa_pkg::f3_and, 1'b0, 5'd21, 5'd20, 5'd18),
            32'h0000_0150, 5'd21, 32'h7fff_fee3, 1'b0);
    add_row("add_same_reg", r_type_word(rv32_isa_pkg::f3_add_sub, 1'b0, 5'd21, 5'd21, 5'd21),
            32'h0000_0154, 5'd21, 32'hffff_fdc6, 1'b0);
    // x21 sits in both E and W here, the younger copy must win
    add_row("sub_e_over_w", r_type_word(rv32_isa_pkg::f3_add_sub, 1'b1, 5'd23, 5'd21, 5'd3),
            32'h0000_0158, 5'd23, 32'hffff_fdc5, 1'b0);

    add_row("lui", u_type_word(rv32_isa_pkg::op_lui, 5'd24, 20'habcde),
            32'h0000_015c, 5'd24, 32'habcd_e000, 1'b0);
    add_row("auipc", u_type_word(rv32_isa_pkg::op_auipc, 5'd25, 20'h12345),
            32'h0000_0160, 5'd25, 32'h1234_5160, 1'b0);
    add_row("add_lui_auipc", r_type_word(rv32_isa_pkg::f3_add_sub, 1'b0, 5'd26, 5'd24, 5'd25),
            32'h0000_0164, 5'd26, 32'hbe02_3160, 1'b0);
    add_row("auipc_neg", u_type_word(rv32_isa_pkg::op_auipc, 5'd27, 20'hfffff),
            32'h0000_0168, 5'd27, 32'hffff_f168, 1'b0);

    // results aimed at x0 retire but are never stored or forwarded
    add_row("addi_x0", i_type_word(rv32_isa_pkg::f3_add_sub, 5'd0, 5'd1, 12'h055),
            32'h0000_016c, 5'd0, 32'h0000_0178, 1'b0);
    add_row("read_x0", r_type_word(rv32_isa_pkg::f3_add_sub, 1'b0, 5'd28, 5'd0, 5'd1),
            32'h0000_0170, 5'd28, 32'h0000_0123, 1'b0);
    add_row("lui_x0", u_type_word(rv32_isa_pkg::op_lui, 5'd0, 20'h12345),
            32'h0000_0174, 5'd0, 32'h1234_5000, 1'b0);
    add_row("or_x0_x0", r_type_word(rv32_isa_pkg::f3_or, 1'b0, 5'd29, 5'd0, 5'd0),
            32'h0000_0178, 5'd29, 32'h0000_0000, 1'b0);

    add_row("all_zero", 32'h0000_0000,
            32'h0000_017c, 5'd0, 32'h0000_0000, 1'b1);
    // lw x1, 0(x2)
    add_row("load", {12'h000, 5'd2, 3'b010, 5'd1, 7'b000_0011},
            32'h0000_0180, 5'd1, 32'h0000_0000, 1'b1);
    add_row("x1_kept", r_type_word(rv32_isa_pkg::f3_add_sub, 1'b0, 5'd30, 5'd1, 5'd0),
            32'h0000_0184, 5'd30, 32'h0000_0123, 1'b0);
    // RV32M funct7 on an OP word
    add_row("bad_funct7",
            {7'b000_0001, 5'd2, 5'd1, rv32_isa_pkg::f3_add_sub, 5'd7, rv32_isa_pkg::op_reg},
            32'h0000_0188, 5'd7, 32'h0000_0000, 1'b1);
    add_row("x7_kept", i_type_word(rv32_isa_pkg::f3_add_sub, 5'd31, 5'd7, 12'h000),
            32'h0000_018c, 5'd31, 32'h0000_01f3, 1'b0);

    allow_gaps = 1'b1;
    add_row("gap_addi", i_type_word(rv32_isa_pkg::f3_add_sub, 5'd5, 5'd1, 12'h001),
            32'h0000_0190, 5'd5, 32'h0000_0124, 1'b0);
    add_row("gap_sub", r_type_word(rv32_isa_pkg::f3_add_sub, 1'b1, 5'd6, 5'd5, 5'd1),
            32'h0000_0194, 5'd6, 32'h0000_0001, 1'b0);
    add_row("gap_sra", r_type_word(rv32_isa_pkg::f3_srl_sra, 1'b1, 5'd7, 5'd2, 5'd6),
            32'h0000_0198, 5'd7, 32'hffff_fffd, 1'b0);
    add_row("gap_sltu", r_type_word(rv32_isa_pkg::f3_sltu, 1'b0, 5'd8, 5'd6, 5'd7),
            32'h0000_019c, 5'd8, 32'h0000_0001, 1'b0);
    add_row("gap_auipc", u_type_word(rv32_isa_pkg::op_auipc, 5'd9, 20'h00001),
            32'h0000_01a0, 5'd9, 32'h0000_11a0, 1'b0);
    add_row("gap_xor", r_type_word(rv32_isa_pkg::f3_xor, 1'b0, 5'd10, 5'd9, 5'd7),
            32'h0000_01a4, 5'd10, 32'hffff_ee5d, 1'b0);
  endtask

  task automatic check_word(input string name, input pipe_pkg::word_t expected,
                            input pipe_pkg::word_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_idx(input string name, input pipe_pkg::reg_idx_t expected,
                           input pipe_pkg::reg_idx_t actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      value_errors++;
      $display("FAIL %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // inputs are driven one step after the edge, so ready is settled here
  task automatic drive_row(input int idx);
    inst_valid = 1'b1;
    inst       = row_inst[idx];
    pc         = row_pc[idx];
    while (!inst_ready) begin
      @(posedge clock);
      #1;
    end
    @(posedge clock);
    #1;
    accept_cycle.push_back(cycle_count);
  endtask

  task automatic check_retirement();
    int unsigned latency;
    string       name;
    if (next_check >= row_name.size()) begin
      protocol_errors++;
      $display("unexpected extra result at cycle %0d: rd %0d, data %h",
               cycle_count, wb_rd, wb_data);
    end else if (next_check >= accept_cycle.size()) begin
      protocol_errors++;
      $display("result at cycle %0d arrived before %s was accepted",
               cycle_count, row_name[next_check]);
    end else begin
      name    = row_name[next_check];
      latency = cycle_count - accept_cycle[next_check];
      if (latency != 2) begin
        protocol_errors++;
        $display("%s retired %0d cycles after acceptance instead of 2", name, latency);
      end
      check_idx({name, " wb_rd"}, row_rd[next_check], wb_rd);
      check_word({name, " wb_data"}, row_data[next_check], wb_data);
      check_flag({name, " wb_illegal"}, row_illegal[next_check], wb_illegal);
      next_check++;
    end
  endtask

  task automatic print_counts();
    $display("results checked: %0d of %0d, value errors: %0d, protocol errors: %0d",
             next_check, row_name.size(), value_errors, protocol_errors);
  endtask

  // writeback monitor, sampled away from the rising edge
  initial begin
    forever begin
      @(negedge clock);
      if (!reset && wb_valid) begin
        check_retirement();
      end
    end
  end

  // the first falling edge comes after the table and the limit are set
  initial begin
    @(negedge clock);
    while (cycle_count < cycle_limit) begin
      @(negedge clock);
    end
    $display("timeout after %0d cycles, %0d of %0d results retired",
             cycle_count, next_check, row_name.size());
    print_counts();
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int gap;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    allow_gaps = 1'b0;
    void'($urandom(32'h7a94_7f03));
    build_table();
    cycle_limit = 4 * row_name.size() * (1 + max_gap) + 20;

    @(negedge clock);
    check_flag("reset inst_ready", 1'b0, inst_ready);
    check_flag("reset wb_valid", 1'b0, wb_valid);
    wait (reset == 1'b0);

    for (int i = 0; i < row_name.size(); i++) begin
      if (row_gap[i]) begin
        gap        = $urandom_range(max_gap, 0);
        inst_valid = 1'b0;
        repeat (gap) begin
          @(posedge clock);
          #1;
        end
      end
      drive_row(i);
    end
    inst_valid = 1'b0;

    while (next_check < row_name.size()) begin
      @(negedge clock);
    end
    // a few quiet cycles catch results that were never issued
    repeat (4) @(negedge clock);

    print_counts();
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
source/rv32_isa_pkg.sv
source/pipe_pkg.sv
source/inst_decoder.sv
source/register_file.sv
source/int_alu.sv
source/pipe_control.sv
source/int_core.sv
testbench/clock_gen.sv
testbench/core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module core_tb -f all.f

output=$(./obj_dir/Vcore_tb)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
  exit 0
else
  exit 1
fi
